//--- verilog/memtest_pkg.sv
/*
 * memtest package
 * bus widths, burst geometry, test window, pattern rule and the
 * sequencer state type shared by the DDR self-test block
 */
package memtest_pkg;

	// ------------------------------
	// bus geometry
	// ------------------------------
	// byte address: [32] cs, [31:15] row, [14:12] bank, [11:2] col, [1:0] datapath
	localparam int ADDR_W = 33;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// INCR bursts of four 32-bit beats
	localparam int BURST_BEATS = 4;
	localparam int BEAT_CNT_W = $clog2(BURST_BEATS);
	localparam logic [ADDR_W-1:0] BURST_BYTES = ADDR_W'(BURST_BEATS * STRB_W);
	localparam logic [7:0] AXI_LEN = 8'(BURST_BEATS - 1);
	localparam logic [2:0] AXI_SIZE = 3'($clog2(STRB_W));
	localparam logic [1:0] AXI_BURST_INCR = 2'b01;
	localparam logic [1:0] AXI_OKAY = 2'b00;
	// read bursts allowed in flight
	localparam int RD_MAX_OUTST = 2;

	// ------------------------------
	// test window, stop is exclusive
	// ------------------------------
	localparam logic [ADDR_W-1:0] TEST_START = 33'h0_0000_0000;
	localparam logic [ADDR_W-1:0] TEST_STOP = 33'h0_0000_0100;
	localparam logic [DATA_W-1:0] PATTERN_SEED = 32'hA5C3_0F1E;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WRITE,
		ST_WRITE_DRAIN,
		ST_READ,
		ST_READ_DRAIN,
		ST_DONE
	} memtest_state_t;

	// data word stored at a byte address
	function automatic logic [DATA_W-1:0] memtest_pattern(input logic [ADDR_W-1:0] addr);
		return addr[DATA_W-1:0] ^ PATTERN_SEED;
	endfunction

endpackage

//--- verilog/memtest_cmd_if.sv
/*
 * memtest burst command link
 * carries one burst start address from the sequencer to a channel
 * master, plus the master's idle and error status back
 */
`timescale 1ns/1ps

interface memtest_cmd_if;
	import memtest_pkg::*;

	// command handshake, valid and addr hold until ready
	logic              cmd_valid;
	logic              cmd_ready;
	logic [ADDR_W-1:0] cmd_addr;
	// no burst in progress
	logic              idle;
	// one-cycle failure pulse and the byte address involved
	logic              err;
	logic [ADDR_W-1:0] err_addr;

	modport seq (
		output cmd_valid,
		output cmd_addr,
		input  cmd_ready,
		input  idle,
		input  err,
		input  err_addr
	);

	modport master (
		input  cmd_valid,
		input  cmd_addr,
		output cmd_ready,
		output idle,
		output err,
		output err_addr
	);

endinterface

//--- verilog/memtest_sequencer.sv
/*
 * memtest sequencer
 * walks the test window once with write bursts, then with read
 * bursts, and latches the first failure and its address
 */
`timescale 1ns/1ps

module memtest_sequencer (
	input  logic                           iAxiCLK,
	input  logic                           iAxiRST,
	input  logic                           i_cfg_done,
	memtest_cmd_if.seq                     wr,
	memtest_cmd_if.seq                     rd,
	output logic                           o_test_run,
	output logic                           o_test_done,
	output logic                           o_test_fail,
	output logic [memtest_pkg::ADDR_W-1:0] o_fail_addr
);
	import memtest_pkg::*;

	memtest_state_t    r_state;
	// current burst start address
	logic [ADDR_W-1:0] r_addr;
	logic              last_burst;
	logic              any_err;
	logic [ADDR_W-1:0] err_addr;

	assign last_burst = (r_addr == TEST_STOP - BURST_BYTES);

	// one command per state, both share the walker
	assign wr.cmd_valid = (r_state == ST_WRITE);
	assign wr.cmd_addr  = r_addr;
	assign rd.cmd_valid = (r_state == ST_READ);
	assign rd.cmd_addr  = r_addr;

	// write errors come first in time
	assign any_err  = wr.err | rd.err;
	assign err_addr = wr.err ? wr.err_addr : rd.err_addr;

	always_ff @(posedge iAxiCLK)
	begin
		if (iAxiRST)
		begin
			r_state     <= ST_IDLE;
			r_addr      <= TEST_START;
			o_test_run  <= 1'b0;
			o_test_done <= 1'b0;
			o_test_fail <= 1'b0;
			o_fail_addr <= '0;
		end
		else if (o_test_run && any_err)
		begin
			// abort on the first failure from either master
			r_state     <= ST_DONE;
			o_test_run  <= 1'b0;
			o_test_done <= 1'b1;
			o_test_fail <= 1'b1;
			o_fail_addr <= err_addr;
		end
		else
		begin
			case (r_state)
				ST_IDLE:
				begin
					// wait for controller config
					if (i_cfg_done)
					begin
						r_state    <= ST_WRITE;
						r_addr     <= TEST_START;
						o_test_run <= 1'b1;
					end
				end
				ST_WRITE:
				begin
					if (wr.cmd_ready)
					begin
						if (last_burst)
							r_state <= ST_WRITE_DRAIN;
						else
							r_addr <= r_addr + BURST_BYTES;
					end
				end
				ST_WRITE_DRAIN:
				begin
					// all B responses back
					if (wr.idle)
					begin
						r_state <= ST_READ;
						r_addr  <= TEST_START;
					end
				end
				ST_READ:
				begin
					if (rd.cmd_ready)
					begin
						if (last_burst)
							r_state <= ST_READ_DRAIN;
						else
							r_addr <= r_addr + BURST_BYTES;
					end
				end
				ST_READ_DRAIN:
				begin
					if (rd.idle)
					begin
						r_state     <= ST_DONE;
						o_test_run  <= 1'b0;
						o_test_done <= 1'b1;
					end
				end
				ST_DONE:
					r_state <= ST_DONE;
				default:
					r_state <= ST_IDLE;
			endcase
		end
	end

	// status flags are set and cleared on separate transitions
	a_run_done_excl: assert property (@(posedge iAxiCLK) disable iff (iAxiRST)
		!(o_test_run && o_test_done));

	// walker stays inside the window on both passes
	a_cmd_in_window: assert property (@(posedge iAxiCLK) disable iff (iAxiRST)
		(wr.cmd_valid || rd.cmd_valid) |-> (r_addr < TEST_STOP));

endmodule

//--- verilog/axi_write_master.sv
/*
 * AXI4 write master
 * writes one INCR pattern burst per command over AW, W and B,
 * and reports a non-OKAY write response
 */
`timescale 1ns/1ps

module axi_write_master (
	input  logic                           iAxiCLK,
	input  logic                           iAxiRST,
	memtest_cmd_if.master                  cmd,
	output logic [memtest_pkg::ADDR_W-1:0] o_awaddr,
	output logic                           o_awvalid,
	input  logic                           i_awready,
	output logic [memtest_pkg::DATA_W-1:0] o_wdata,
	output logic [memtest_pkg::STRB_W-1:0] o_wstrb,
	output logic                           o_wlast,
	output logic                           o_wvalid,
	input  logic                           i_wready,
	input  logic [1:0]                     i_bresp,
	input  logic                           i_bvalid,
	output logic                           o_bready
);
	import memtest_pkg::*;

	logic                  r_busy;
	logic                  r_awvalid;
	logic                  r_wvalid;
	logic [BEAT_CNT_W-1:0] r_beat;
	// burst start address, also the error address
	logic [ADDR_W-1:0]     r_addr;
	logic                  r_err;
	logic                  cmd_fire;
	logic                  w_fire;
	logic                  b_fire;

	// ------------------------------
	// command side
	// ------------------------------
	// one burst at a time
	assign cmd.cmd_ready = ~r_busy;
	assign cmd.idle      = ~r_busy;
	assign cmd.err       = r_err;
	assign cmd.err_addr  = r_addr;

	assign cmd_fire = cmd.cmd_valid & ~r_busy;
	assign w_fire   = r_wvalid & i_wready;
	assign b_fire   = i_bvalid & o_bready;

	// ------------------------------
	// AXI outputs
	// ------------------------------
	assign o_awaddr  = r_addr;
	assign o_awvalid = r_awvalid;
	// beat data follows from beat counter, stable until WREADY
	assign o_wdata   = memtest_pattern(r_addr + ADDR_W'(r_beat * STRB_W));
	assign o_wstrb   = {STRB_W{1'b1}};
	assign o_wlast   = (r_beat == BEAT_CNT_W'(BURST_BEATS - 1));
	assign o_wvalid  = r_wvalid;
	// response accepted once the last beat is out
	assign o_bready  = r_busy & ~r_wvalid;

	always_ff @(posedge iAxiCLK)
	begin
		if (cmd_fire)
			r_addr <= cmd.cmd_addr;
	end

	always_ff @(posedge iAxiCLK)
	begin
		if (iAxiRST)
		begin
			r_busy    <= 1'b0;
			r_awvalid <= 1'b0;
			r_wvalid  <= 1'b0;
			r_beat    <= '0;
			r_err     <= 1'b0;
		end
		else
		begin
			r_err <= 1'b0;
			if (cmd_fire)
			begin
				// AW and W start together next cycle
				r_busy    <= 1'b1;
				r_awvalid <= 1'b1;
				r_wvalid  <= 1'b1;
				r_beat    <= '0;
			end
			else
			begin
				// address sub-engine
				if (r_awvalid && i_awready)
					r_awvalid <= 1'b0;
				// data sub-engine, no wait on AWREADY
				if (w_fire)
				begin
					if (o_wlast)
						r_wvalid <= 1'b0;
					else
						r_beat <= r_beat + 1'b1;
				end
				// burst done on B
				if (b_fire)
				begin
					r_busy <= 1'b0;
					r_err  <= (i_bresp != AXI_OKAY);
				end
			end
		end
	end

	a_awvalid_hold: assert property (@(posedge iAxiCLK) disable iff (iAxiRST)
		(o_awvalid && !i_awready) |=> o_awvalid);

endmodule

//--- verilog/axi_read_master.sv
/*
 * AXI4 read master
 * issues read bursts with up to two in flight and checks every
 * beat against the pattern, RRESP and RLAST position
 */
`timescale 1ns/1ps

module axi_read_master (
	input  logic                           iAxiCLK,
	input  logic                           iAxiRST,
	memtest_cmd_if.master                  cmd,
	output logic [memtest_pkg::ADDR_W-1:0] o_araddr,
	output logic                           o_arvalid,
	input  logic                           i_arready,
	input  logic [memtest_pkg::DATA_W-1:0] i_rdata,
	input  logic [1:0]                     i_rresp,
	input  logic                           i_rlast,
	input  logic                           i_rvalid,
	output logic                           o_rready
);
	import memtest_pkg::*;

	logic [ADDR_W-1:0]                 r_araddr;
	logic                              r_arvalid;
	// bursts accepted and not yet fully returned
	logic [$clog2(RD_MAX_OUTST+1)-1:0] r_outst;
	// start addresses in AR order
	logic [ADDR_W-1:0]                 r_q_addr [RD_MAX_OUTST];
	logic [$clog2(RD_MAX_OUTST)-1:0]   r_wr_ptr;
	logic [$clog2(RD_MAX_OUTST)-1:0]   r_rd_ptr;
	logic [BEAT_CNT_W-1:0]             r_beat;
	logic                              r_err;
	logic [ADDR_W-1:0]                 r_err_addr;
	logic                              cmd_fire;
	logic                              r_fire;
	logic                              last_beat;
	logic                              beat_bad;
	logic [ADDR_W-1:0]                 exp_addr;

	// ------------------------------
	// command side
	// ------------------------------
	// single AR slot, limited by outstanding count
	assign cmd.cmd_ready = ~r_arvalid & (r_outst < RD_MAX_OUTST);
	assign cmd.idle      = (r_outst == '0);
	assign cmd.err       = r_err;
	assign cmd.err_addr  = r_err_addr;

	assign cmd_fire = cmd.cmd_valid & cmd.cmd_ready;
	assign r_fire   = i_rvalid & o_rready;

	assign o_araddr  = r_araddr;
	assign o_arvalid = r_arvalid;
	assign o_rready  = (r_outst != '0);

	// ------------------------------
	// beat check
	// ------------------------------
	assign exp_addr  = r_q_addr[r_rd_ptr] + ADDR_W'(r_beat * STRB_W);
	assign last_beat = (r_beat == BEAT_CNT_W'(BURST_BEATS - 1));
	// bad data, bad response or RLAST off the 4th beat
	assign beat_bad  = (i_rdata != memtest_pattern(exp_addr)) ||
		(i_rresp != AXI_OKAY) || (i_rlast != last_beat);

	always_ff @(posedge iAxiCLK)
	begin
		if (cmd_fire)
		begin
			r_q_addr[r_wr_ptr] <= cmd.cmd_addr;
			r_araddr           <= cmd.cmd_addr;
		end
		if (r_fire)
			r_err_addr <= exp_addr;
	end

	always_ff @(posedge iAxiCLK)
	begin
		if (iAxiRST)
		begin
			r_arvalid <= 1'b0;
			r_outst   <= '0;
			r_wr_ptr  <= '0;
			r_rd_ptr  <= '0;
			r_beat    <= '0;
			r_err     <= 1'b0;
		end
		else
		begin
			r_err <= 1'b0;
			if (cmd_fire)
			begin
				r_arvalid <= 1'b1;
				r_wr_ptr  <= r_wr_ptr + 1'b1;
			end
			else if (r_arvalid && i_arready)
				r_arvalid <= 1'b0;
			// beats return in AR order
			if (r_fire)
			begin
				r_err <= beat_bad;
				if (last_beat)
				begin
					r_beat   <= '0;
					r_rd_ptr <= r_rd_ptr + 1'b1;
				end
				else
					r_beat <= r_beat + 1'b1;
			end
			case ({cmd_fire, r_fire && last_beat})
				2'b10:   r_outst <= r_outst + 1'b1;
				2'b01:   r_outst <= r_outst - 1'b1;
				default: r_outst <= r_outst;
			endcase
		end
	end

	a_outst_limit: assert property (@(posedge iAxiCLK) disable iff (iAxiRST)
		r_outst <= RD_MAX_OUTST);

endmodule

//--- verilog/memtest_top.sv
/*
 * DDR memory self-test top
 * AXI4 master port and test status, built from the sequencer
 * and the write and read channel masters
 */
`timescale 1ns/1ps

module memtest_top (
	input  logic                           iAxiCLK,
	input  logic                           iAxiRST,
	input  logic                           i_cfg_done,
	// write address
	output logic [memtest_pkg::ADDR_W-1:0] o_awaddr_0,
	output logic [7:0]                     o_awlen_0,
	output logic [2:0]                     o_awsize_0,
	output logic [1:0]                     o_awburst_0,
	output logic                           o_awvalid_0,
	input  logic                           i_awready_0,
	// write data
	output logic [memtest_pkg::DATA_W-1:0] o_wdata_0,
	output logic [memtest_pkg::STRB_W-1:0] o_wstrb_0,
	output logic                           o_wlast_0,
	output logic                           o_wvalid_0,
	input  logic                           i_wready_0,
	// write response
	input  logic [1:0]                     i_bresp_0,
	input  logic                           i_bvalid_0,
	output logic                           o_bready_0,
	// read address
	output logic [memtest_pkg::ADDR_W-1:0] o_araddr_0,
	output logic [7:0]                     o_arlen_0,
	output logic [2:0]                     o_arsize_0,
	output logic [1:0]                     o_arburst_0,
	output logic                           o_arvalid_0,
	input  logic                           i_arready_0,
	// read data
	input  logic [memtest_pkg::DATA_W-1:0] i_rdata_0,
	input  logic [1:0]                     i_rresp_0,
	input  logic                           i_rlast_0,
	input  logic                           i_rvalid_0,
	output logic                           o_rready_0,
	// test status
	output logic                           o_test_run,
	output logic                           o_test_done,
	output logic                           o_test_fail,
	output logic [memtest_pkg::ADDR_W-1:0] o_fail_addr
);
	import memtest_pkg::*;

	memtest_cmd_if wr_cmd ();
	memtest_cmd_if rd_cmd ();

	// fixed burst shape on both address channels
	// ID, lock, QoS and sideband stay at their zero defaults in the controller
	assign o_awlen_0   = AXI_LEN;
	assign o_awsize_0  = AXI_SIZE;
	assign o_awburst_0 = AXI_BURST_INCR;
	assign o_arlen_0   = AXI_LEN;
	assign o_arsize_0  = AXI_SIZE;
	assign o_arburst_0 = AXI_BURST_INCR;

	memtest_sequencer u_seq (
		.iAxiCLK     (iAxiCLK),
		.iAxiRST     (iAxiRST),
		.i_cfg_done  (i_cfg_done),
		.wr          (wr_cmd),
		.rd          (rd_cmd),
		.o_test_run  (o_test_run),
		.o_test_done (o_test_done),
		.o_test_fail (o_test_fail),
		.o_fail_addr (o_fail_addr)
	);

	axi_write_master u_wr (
		.iAxiCLK   (iAxiCLK),
		.iAxiRST   (iAxiRST),
		.cmd       (wr_cmd),
		.o_awaddr  (o_awaddr_0),
		.o_awvalid (o_awvalid_0),
		.i_awready (i_awready_0),
		.o_wdata   (o_wdata_0),
		.o_wstrb   (o_wstrb_0),
		.o_wlast   (o_wlast_0),
		.o_wvalid  (o_wvalid_0),
		.i_wready  (i_wready_0),
		.i_bresp   (i_bresp_0),
		.i_bvalid  (i_bvalid_0),
		.o_bready  (o_bready_0)
	);

	axi_read_master u_rd (
		.iAxiCLK   (iAxiCLK),
		.iAxiRST   (iAxiRST),
		.cmd       (rd_cmd),
		.o_araddr  (o_araddr_0),
		.o_arvalid (o_arvalid_0),
		.i_arready (i_arready_0),
		.i_rdata   (i_rdata_0),
		.i_rresp   (i_rresp_0),
		.i_rlast   (i_rlast_0),
		.i_rvalid  (i_rvalid_0),
		.o_rready  (o_rready_0)
	);

endmodule

//--- testbench/axi_mem_model.sv
/*
 * AXI4 slave memory model
 * 64-word memory with random ready and valid gaps, read and write
 * fault injection, and monitors for beat order and read outstanding
 */
`timescale 1ns/1ps

module axi_mem_model #(
	parameter int SEED = 1
) (
	input  logic                           iAxiCLK,
	input  logic                           iAxiRST,
	// case settings, changed only during reset
	input  logic [2:0]                     i_mode,
	input  logic [memtest_pkg::ADDR_W-1:0] i_fault_addr,
	input  logic [memtest_pkg::DATA_W-1:0] i_fault_mask,
	input  logic [memtest_pkg::ADDR_W-1:0] i_awaddr,
	input  logic                           i_awvalid,
	output logic                           o_awready = 1'b0,
	input  logic [memtest_pkg::DATA_W-1:0] i_wdata,
	input  logic                           i_wlast,
	input  logic                           i_wvalid,
	output logic                           o_wready = 1'b0,
	output logic [1:0]                     o_bresp = 2'b00,
	output logic                           o_bvalid = 1'b0,
	input  logic                           i_bready,
	input  logic [memtest_pkg::ADDR_W-1:0] i_araddr,
	input  logic                           i_arvalid,
	output logic                           o_arready = 1'b0,
	output logic [memtest_pkg::DATA_W-1:0] o_rdata = '0,
	output logic [1:0]                     o_rresp = 2'b00,
	output logic                           o_rlast = 1'b0,
	output logic                           o_rvalid = 1'b0,
	input  logic                           i_rready,
	// monitor results
	output int                             o_ar_count = 0,
	output logic                           o_outst_err = 1'b0,
	output logic                           o_beat_err = 1'b0
);
	import memtest_pkg::*;

	logic [DATA_W-1:0] mem [64];
	integer            seed = SEED;
	// write burst being collected
	logic              aw_have;
	logic [ADDR_W-1:0] aw_addr;
	logic [DATA_W-1:0] wbuf [4];
	logic [2:0]        w_cnt;
	// accepted read bursts, oldest first
	logic [ADDR_W-1:0] ar_q [$];
	logic [1:0]        r_beat;
	logic [ADDR_W-1:0] rd_addr;
	// taken at the clock edge
	logic              rst_s;
	logic [2:0]        mode_s;
	logic [ADDR_W-1:0] fa_s;
	logic [DATA_W-1:0] fm_s;
	logic              awv_s;
	logic              aw_hs;
	logic [ADDR_W-1:0] aw_a;
	logic              w_hs;
	logic [DATA_W-1:0] w_d;
	logic              wlast_s;
	logic              b_hs;
	logic              ar_hs;
	logic [ADDR_W-1:0] ar_a;
	logic              r_hs;

	// ready or valid this cycle, heavy mode passes far fewer
	function logic pass_gap();
		int roll;
		roll = $random(seed) & 15;
		return roll >= ((mode_s == 3'd4) ? 10 : 3);
	endfunction

	always @(posedge iAxiCLK)
	begin
		// DUT side before it moves
		rst_s   = iAxiRST;
		mode_s  = i_mode;
		fa_s    = i_fault_addr;
		fm_s    = i_fault_mask;
		awv_s   = i_awvalid;
		aw_hs   = i_awvalid && o_awready;
		aw_a    = i_awaddr;
		w_hs    = i_wvalid && o_wready;
		w_d     = i_wdata;
		wlast_s = i_wlast;
		b_hs    = o_bvalid && i_bready;
		ar_hs   = i_arvalid && o_arready;
		ar_a    = i_araddr;
		r_hs    = o_rvalid && i_rready;
		#1;
		if (rst_s)
		begin
			aw_have     = 1'b0;
			w_cnt       = '0;
			r_beat      = '0;
			ar_q.delete();
			o_awready   = 1'b0;
			o_wready    = 1'b0;
			o_bvalid    = 1'b0;
			o_arready   = 1'b0;
			o_rvalid    = 1'b0;
			o_ar_count  = 0;
			o_outst_err = 1'b0;
			o_beat_err  = 1'b0;
			// stale contents unlike the pattern at every address
			for (int k = 0; k < 64; k++)
				mem[6'(k)] = 32'h3C3C_0000 ^ 32'(k * 4);
		end
		else
		begin
			// ------------------------------
			// write side
			// ------------------------------
			if (w_hs)
			begin
				// address presented or taken by the time of the beat
				if (!aw_have && !awv_s)
					o_beat_err = 1'b1;
				if (wlast_s != (w_cnt == 3'd3))
					o_beat_err = 1'b1;
				wbuf[w_cnt[1:0]] = w_d;
				w_cnt = w_cnt + 3'd1;
			end
			if (aw_hs)
			begin
				aw_have = 1'b1;
				aw_addr = aw_a;
			end
			if (b_hs)
				o_bvalid = 1'b0;
			// whole burst in, commit and respond
			if (aw_have && w_cnt == 3'd4 && !o_bvalid && pass_gap())
			begin
				for (int k = 0; k < 4; k++)
					mem[aw_addr[7:2] + 6'(k)] = wbuf[2'(k)];
				o_bresp  = (mode_s == 3'd3 && aw_addr[ADDR_W-1:4] == fa_s[ADDR_W-1:4]) ?
					2'b10 : AXI_OKAY;
				o_bvalid = 1'b1;
				aw_have  = 1'b0;
				w_cnt    = '0;
			end
			o_awready = !aw_have && pass_gap();
			o_wready  = (w_cnt < 3'd4) && pass_gap();
			// ------------------------------
			// read side
			// ------------------------------
			if (r_hs)
			begin
				o_rvalid = 1'b0;
				if (r_beat == 2'd3)
					void'(ar_q.pop_front());
				r_beat = r_beat + 2'd1;
			end
			if (ar_hs)
			begin
				ar_q.push_back(ar_a);
				o_ar_count++;
				if (ar_q.size() > 2)
					o_outst_err = 1'b1;
			end
			if (!o_rvalid && ar_q.size() > 0 && pass_gap())
			begin
				rd_addr  = ar_q[0] + ADDR_W'({r_beat, 2'b00});
				o_rdata  = mem[rd_addr[7:2]] ^
					((mode_s == 3'd1 && rd_addr == fa_s) ? fm_s : '0);
				o_rresp  = (mode_s == 3'd2 && rd_addr == fa_s) ? 2'b10 : AXI_OKAY;
				o_rlast  = (r_beat == 2'd3);
				o_rvalid = 1'b1;
			end
			o_arready = pass_gap();
		end
	end

endmodule

//--- testbench/tb_memtest.sv
/*
 * testbench for the DDR self-test block
 * runs every line of the case file against the AXI memory model
 */
`timescale 1ns/1ps

module tb_memtest;
	import memtest_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RAND_SEED = 49172;
	localparam int MAX_CASES = 32;
	// 32 bursts of 4 beats at 8 cycles worst case, plus setup
	localparam int CASE_CYCLES = 32 * 4 * 8 + 100;
	localparam logic [35:0] NO_CASE = '1;
	// constant mixed into every stored word
	localparam logic [31:0] WORD_SEED = 32'hA5C3_0F1E;

	logic              iAxiCLK = 1'b0;
	logic              iAxiRST;
	logic              i_cfg_done;
	logic [ADDR_W-1:0] awaddr;
	logic [7:0]        awlen;
	logic [2:0]        awsize;
	logic [1:0]        awburst;
	logic              awvalid;
	logic              awready;
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic              wlast;
	logic              wvalid;
	logic              wready;
	logic [1:0]        bresp;
	logic              bvalid;
	logic              bready;
	logic [ADDR_W-1:0] araddr;
	logic [7:0]        arlen;
	logic [2:0]        arsize;
	logic [1:0]        arburst;
	logic              arvalid;
	logic              arready;
	logic [DATA_W-1:0] rdata;
	logic [1:0]        rresp;
	logic              rlast;
	logic              rvalid;
	logic              rready;
	logic              test_run;
	logic              test_done;
	logic              test_fail;
	logic [ADDR_W-1:0] fail_addr;
	// model settings and monitors
	logic [2:0]        mode;
	logic [ADDR_W-1:0] fault_addr;
	logic [DATA_W-1:0] fault_mask;
	int                ar_count;
	logic              outst_err;
	logic              beat_err;
	// five words per case
	logic [35:0]       case_words [5*MAX_CASES];
	int                num_cases = 0;
	int                cycle_count = 0;
	int                cycle_limit = 0;

	always #(CLK_PERIOD/2) iAxiCLK = ~iAxiCLK;

	memtest_top dut (
		.iAxiCLK(iAxiCLK), .iAxiRST(iAxiRST), .i_cfg_done(i_cfg_done),
		.o_awaddr_0(awaddr), .o_awlen_0(awlen), .o_awsize_0(awsize),
		.o_awburst_0(awburst), .o_awvalid_0(awvalid), .i_awready_0(awready),
		.o_wdata_0(wdata), .o_wstrb_0(wstrb), .o_wlast_0(wlast),
		.o_wvalid_0(wvalid), .i_wready_0(wready),
		.i_bresp_0(bresp), .i_bvalid_0(bvalid), .o_bready_0(bready),
		.o_araddr_0(araddr), .o_arlen_0(arlen), .o_arsize_0(arsize),
		.o_arburst_0(arburst), .o_arvalid_0(arvalid), .i_arready_0(arready),
		.i_rdata_0(rdata), .i_rresp_0(rresp), .i_rlast_0(rlast),
		.i_rvalid_0(rvalid), .o_rready_0(rready),
		.o_test_run(test_run), .o_test_done(test_done),
		.o_test_fail(test_fail), .o_fail_addr(fail_addr)
	);

	axi_mem_model #(.SEED(RAND_SEED)) u_mem (
		.iAxiCLK(iAxiCLK), .iAxiRST(iAxiRST), .i_mode(mode),
		.i_fault_addr(fault_addr), .i_fault_mask(fault_mask),
		.i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
		.i_wdata(wdata), .i_wlast(wlast), .i_wvalid(wvalid), .o_wready(wready),
		.o_bresp(bresp), .o_bvalid(bvalid), .i_bready(bready),
		.i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
		.o_rdata(rdata), .o_rresp(rresp), .o_rlast(rlast), .o_rvalid(rvalid),
		.i_rready(rready), .o_ar_count(ar_count),
		.o_outst_err(outst_err), .o_beat_err(beat_err)
	);

	// ------------------------------
	// checking
	// ------------------------------
	task automatic stop_on_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
			stop_on_failure();
		end
	endtask

	// stored word is the low 32 address bits XOR the seed
	function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] a);
		return a[31:0] ^ WORD_SEED;
	endfunction

	// run limit over all cases
	always @(posedge iAxiCLK)
	begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("timeout: %0d cycles passed before all cases finished", cycle_count);
			stop_on_failure();
		end
	end

	task automatic run_case(input int idx);
		logic [7:0]        base;
		logic [2:0]        c_mode;
		logic [ADDR_W-1:0] c_addr;
		logic [DATA_W-1:0] c_mask;
		logic              c_fail;
		logic [ADDR_W-1:0] c_fail_addr;
		logic [ADDR_W-1:0] a;
		base        = 8'(5 * idx);
		c_mode      = case_words[base][2:0];
		c_addr      = case_words[base + 8'd1][ADDR_W-1:0];
		c_mask      = case_words[base + 8'd2][DATA_W-1:0];
		c_fail      = case_words[base + 8'd3][0];
		c_fail_addr = case_words[base + 8'd4][ADDR_W-1:0];
		$display("case %0d: mode %0d fault 0x%0h", idx, c_mode, c_addr);
		// reset, model set up meanwhile
		@(posedge iAxiCLK);
		#1;
		iAxiRST    = 1'b1;
		i_cfg_done = 1'b0;
		mode       = c_mode;
		fault_addr = c_addr;
		fault_mask = c_mask;
		repeat (3) @(posedge iAxiCLK);
		#1;
		iAxiRST = 1'b0;
		// idle until config done
		@(posedge iAxiCLK);
		#1;
		check_value("o_test_run", 64'(test_run), 64'(0));
		check_value("o_test_done", 64'(test_done), 64'(0));
		check_value("o_test_fail", 64'(test_fail), 64'(0));
		i_cfg_done = 1'b1;
		// run one cycle after cfg sampled
		@(posedge iAxiCLK);
		#1;
		check_value("o_test_run", 64'(test_run), 64'(1));
		while (test_done !== 1'b1)
		begin
			@(posedge iAxiCLK);
			#1;
		end
		check_value("o_test_run", 64'(test_run), 64'(0));
		check_value("o_test_fail", 64'(test_fail), 64'(c_fail));
		check_value("o_fail_addr", 64'(fail_addr), 64'(c_fail_addr));
		// result holds until reset
		repeat (4) @(posedge iAxiCLK);
		#1;
		check_value("o_test_done", 64'(test_done), 64'(1));
		check_value("o_test_fail", 64'(test_fail), 64'(c_fail));
		check_value("o_fail_addr", 64'(fail_addr), 64'(c_fail_addr));
		// INCR, 4 beats of 4 bytes
		check_value("o_awlen_0", 64'(awlen), 64'(3));
		check_value("o_awsize_0", 64'(awsize), 64'(2));
		check_value("o_awburst_0", 64'(awburst), 64'(1));
		check_value("o_arlen_0", 64'(arlen), 64'(3));
		check_value("o_arsize_0", 64'(arsize), 64'(2));
		check_value("o_arburst_0", 64'(arburst), 64'(1));
		// full words only
		check_value("o_wstrb_0", 64'(wstrb), 64'hF);
		check_value("outst_err", 64'(outst_err), 64'(0));
		check_value("beat_err", 64'(beat_err), 64'(0));
		if (c_mode == 3'd3)
			check_value("ar_count", 64'(ar_count), 64'(0));
		else
		begin
			// write pass complete, whole window holds the pattern
			for (int i = 0; i < 64; i++)
			begin
				a = TEST_START + ADDR_W'(i * 4);
				check_value($sformatf("mem[0x%0h]", a),
					64'(u_mem.mem[6'(i)]), 64'(expected_word(a)));
			end
		end
	endtask

	initial
	begin
		iAxiRST    = 1'b1;
		i_cfg_done = 1'b0;
		mode       = '0;
		fault_addr = '0;
		fault_mask = '0;
		// unread entries stay as the end marker
		for (int i = 0; i < 5 * MAX_CASES; i++)
			case_words[8'(i)] = NO_CASE;
		$readmemh("testbench/memtest_cases.txt", case_words);
		for (int i = 0; i < MAX_CASES; i++)
		begin
			if (case_words[8'(5 * i)] == NO_CASE)
				break;
			num_cases++;
		end
		if (num_cases == 0)
		begin
			$display("no test cases were read from the case file");
			stop_on_failure();
		end
		else
		begin
			cycle_limit = num_cases * CASE_CYCLES;
			for (int i = 0; i < num_cases; i++)
				run_case(i);
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

//--- list.f
verilog/memtest_pkg.sv
verilog/memtest_cmd_if.sv
verilog/memtest_sequencer.sv
verilog/axi_write_master.sv
verilog/axi_read_master.sv
verilog/memtest_top.sv
testbench/axi_mem_model.sv
testbench/tb_memtest.sv

//--- Makefile
# Verilator build for the DDR memory self-test block
# override on the command line, e.g. make run LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_memtest
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
CASES     ?= testbench/memtest_cases.txt
VFLAGS    ?= --binary --timing --assert

FAIL_MSG := *** TEST FAILED ***
PASS_MSG := *** TEST PASSED ***
SRCS     := $(shell grep -v '^+' $(FILELIST))
SIM      := $(OBJ_DIR)/V$(TOP)

.PHONY: compile run clean
.DEFAULT_GOAL := run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(CASES)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "run ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/memtest_cases.txt
// mode fault_addr fault_mask exp_fail exp_fail_addr
// mode 0 clean, 1 read data flip, 2 read SLVERR, 3 write SLVERR, 4 heavy gaps
0 000000000 00000000 0 000000000
1 000000044 00000001 1 000000044
1 0000000FC 80000000 1 0000000FC
1 000000000 FFFFFFFF 1 000000000
2 000000008 00000000 1 000000008
2 0000000A4 00000000 1 0000000A4
3 000000036 00000000 1 000000030
3 0000000F0 00000000 1 0000000F0
4 000000000 00000000 0 000000000
0 000000000 00000000 0 000000000
